// ==== hw/uart_pkg.sv ====
// UART line constants and state types

package uart_pkg;

    //////////////////////////////
    // Frame and timing constants
    //////////////////////////////

    // Data bits per frame
    localparam int word_bits = 8;

    // clk cycles between oversample ticks
    localparam int clks_per_tick = 4;

    // Oversample ticks per serial bit, so 16 clk cycles per bit
    localparam int ticks_per_bit = 4;

    //////////////////////////////
    // Enumerations
    //////////////////////////////

    // Run-time parity selection
    typedef enum logic [1:0] {
        parity_none,
        parity_even,
        parity_odd
    } parity_e;

    // Transmit FSM
    typedef enum logic [2:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_parity,
        tx_stop
    } tx_state_e;

    // Receive FSM
    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_e;

endpackage

// ==== hw/uart_bus_pkg.sv ====
// UART host and internal word types

package uart_bus_pkg;

    //////////////////////////////
    // Receive side
    //////////////////////////////

    // Received byte with its status flags
    // overrun is only ever set by the controller
    typedef struct packed {
        logic [uart_pkg::word_bits-1:0] data;
        logic                           parity_err;
        logic                           frame_err;
        logic                           overrun;
    } rx_word_t;

    //////////////////////////////
    // Transmit side
    //////////////////////////////

    // Byte to send, room left for later control fields
    typedef struct packed {
        logic [uart_pkg::word_bits-1:0] data;
    } tx_word_t;

endpackage

// ==== hw/uart_baud_gen.sv ====
// Oversample tick generator
`timescale 1ns/1ps

module uart_baud_gen (
    input  logic clk,
    input  logic reset_b,
    output logic tick
);
    import uart_pkg::*;

    // Free-running divider shared by both directions
    logic [$clog2(clks_per_tick)-1:0] div_cnt;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            div_cnt <= '0;
        end else if (div_cnt == clks_per_tick - 1) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // One cycle pulse per divider wrap
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            tick <= 1'b0;
        end else begin
            tick <= (div_cnt == clks_per_tick - 1);
        end
    end

endmodule

// ==== hw/uart_tx_shift.sv ====
// UART transmit shifter
`timescale 1ns/1ps

module uart_tx_shift (
    input  logic                   clk,
    input  logic                   reset_b,
    input  logic                   tick,
    input  uart_pkg::parity_e      parity_mode,
    input  logic                   load,
    input  uart_bus_pkg::tx_word_t load_data,
    output logic                   busy,
    output logic                   txd
);
    import uart_pkg::*;

    tx_state_e                        state;
    logic [$clog2(ticks_per_bit)-1:0] tick_cnt;
    logic [$clog2(word_bits)-1:0]     bit_idx;
    logic [word_bits-1:0]             data_q;
    logic                             parity_bit;
    logic                             bit_end;

    // Byte held for the whole frame
    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= load_data.data;
        end
    end

    // Even parity, inverted for odd mode
    assign parity_bit = (^data_q) ^ (parity_mode == parity_odd);
    assign bit_end    = tick && (tick_cnt == ticks_per_bit - 1);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state    <= tx_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            busy     <= 1'b0;
            txd      <= 1'b1;
        end else begin
            if (load) begin
                busy <= 1'b1;
            end
            if (tick) begin
                tick_cnt <= (bit_end || state == tx_idle) ? '0 : tick_cnt + 1'b1;
            end
            unique case (state)
                tx_idle: begin
                    // Start bit begins on a tick edge
                    if ((busy || load) && tick) begin
                        state <= tx_start;
                        txd   <= 1'b0;
                    end
                end
                tx_start: begin
                    if (bit_end) begin
                        state   <= tx_data;
                        bit_idx <= '0;
                        txd     <= data_q[0];
                    end
                end
                tx_data: begin
                    if (bit_end && bit_idx == word_bits - 1) begin
                        state <= (parity_mode == parity_none) ? tx_stop : tx_parity;
                        txd   <= (parity_mode == parity_none) ? 1'b1 : parity_bit;
                    end else if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        txd     <= data_q[bit_idx + 1'b1];
                    end
                end
                tx_parity: begin
                    if (bit_end) begin
                        state <= tx_stop;
                        txd   <= 1'b1;
                    end
                end
                tx_stop: begin
                    if (bit_end) begin
                        state <= tx_idle;
                        busy  <= 1'b0;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

// ==== hw/uart_rx_sample.sv ====
// UART receive sampler
`timescale 1ns/1ps

module uart_rx_sample (
    input  logic                   clk,
    input  logic                   reset_b,
    input  logic                   tick,
    input  uart_pkg::parity_e      parity_mode,
    input  logic                   rxd,
    output logic                   word_done,
    output uart_bus_pkg::rx_word_t word
);
    import uart_pkg::*;

    rx_state_e                        state;
    logic [$clog2(ticks_per_bit)-1:0] tick_cnt;
    logic [$clog2(word_bits)-1:0]     bit_idx;
    logic [word_bits-1:0]             data_q;
    logic                             parity_err_q;
    logic                             frame_err_q;
    logic                             rxd_meta;
    logic                             rxd_sync;
    logic                             rxd_prev;
    logic                             sample;

    //////////////////////////////
    // Input synchroniser
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // Half a bit into the start bit, whole bits after that
    assign sample = tick && (state == rx_start ? tick_cnt == ticks_per_bit / 2 - 1
                                               : tick_cnt == ticks_per_bit - 1);

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state        <= rx_idle;
            tick_cnt     <= '0;
            bit_idx      <= '0;
            data_q       <= '0;
            parity_err_q <= 1'b0;
            frame_err_q  <= 1'b0;
            word_done    <= 1'b0;
        end else begin
            word_done <= 1'b0;
            if (tick) begin
                tick_cnt <= sample ? '0 : tick_cnt + 1'b1;
            end
            unique case (state)
                rx_idle: begin
                    tick_cnt <= '0;
                    if (!rxd_sync && rxd_prev) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // A high line at mid-bit was only a glitch
                    if (sample) begin
                        state   <= rxd_sync ? rx_idle : rx_data;
                        bit_idx <= '0;
                    end
                end
                rx_data: begin
                    if (sample) begin
                        data_q  <= {rxd_sync, data_q[word_bits-1:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == word_bits - 1) begin
                            state        <= (parity_mode == parity_none) ? rx_stop : rx_parity;
                            parity_err_q <= 1'b0;
                        end
                    end
                end
                rx_parity: begin
                    if (sample) begin
                        state        <= rx_stop;
                        parity_err_q <= rxd_sync ^ (^data_q) ^ (parity_mode == parity_odd);
                    end
                end
                rx_stop: begin
                    if (sample) begin
                        state       <= rx_idle;
                        frame_err_q <= ~rxd_sync;
                        word_done   <= 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    assign word = '{data: data_q, parity_err: parity_err_q, frame_err: frame_err_q,
                    overrun: 1'b0};

endmodule

// ==== hw/uart_ctrl.sv ====
// UART host control block
`timescale 1ns/1ps

module uart_ctrl (
    input  logic                   clk,
    input  logic                   reset_b,
    // Host transmit port
    input  logic                   tx_valid,
    input  uart_bus_pkg::tx_word_t tx_word,
    output logic                   tx_ready,
    // Transmit shifter
    output logic                   load,
    output uart_bus_pkg::tx_word_t load_data,
    input  logic                   busy,
    // Receive sampler
    input  logic                   word_done,
    input  uart_bus_pkg::rx_word_t word,
    // Host receive port
    output logic                   rx_valid,
    output uart_bus_pkg::rx_word_t rx_word,
    input  logic                   rx_ready
);
    import uart_bus_pkg::*;

    rx_word_t rx_hold;

    //////////////////////////////
    // Transmit handshake
    //////////////////////////////

    // Low for the whole frame, including the cycle load is pending
    assign tx_ready = ~busy & ~load;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            load <= 1'b0;
        end else begin
            load <= tx_valid & tx_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            load_data <= tx_word;
        end
    end

    //////////////////////////////
    // Receive holding register
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_valid <= 1'b0;
            rx_hold  <= '{data: '1, default: 1'b0};
        end else if (word_done && (!rx_valid || rx_ready)) begin
            // Free slot, or the held word leaves this cycle
            rx_valid <= 1'b1;
            rx_hold  <= word;
        end else if (word_done) begin
            // Host still busy, new word is lost
            rx_hold.overrun <= 1'b1;
        end else if (rx_valid && rx_ready) begin
            rx_valid        <= 1'b0;
            rx_hold.overrun <= 1'b0;
        end
    end

    assign rx_word = rx_hold;

endmodule

// ==== hw/uart_top.sv ====
// UART subsystem top level
`timescale 1ns/1ps

module uart_top (
    input  logic                   clk,
    input  logic                   reset_b,
    input  uart_pkg::parity_e      parity_mode,
    input  logic                   tx_valid,
    input  uart_bus_pkg::tx_word_t tx_word,
    output logic                   tx_ready,
    output logic                   rx_valid,
    output uart_bus_pkg::rx_word_t rx_word,
    input  logic                   rx_ready,
    input  logic                   rxd,
    output logic                   txd
);
    import uart_bus_pkg::*;

    logic     tick;
    logic     load;
    logic     busy;
    logic     word_done;
    tx_word_t load_data;
    rx_word_t word;

    uart_ctrl u_ctrl (
        .clk       (clk),
        .reset_b   (reset_b),
        .tx_valid  (tx_valid),
        .tx_word   (tx_word),
        .tx_ready  (tx_ready),
        .load      (load),
        .load_data (load_data),
        .busy      (busy),
        .word_done (word_done),
        .word      (word),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word),
        .rx_ready  (rx_ready)
    );

    uart_baud_gen u_baud_gen (.clk(clk), .reset_b(reset_b), .tick(tick));

    uart_tx_shift u_tx_shift (
        .clk         (clk),
        .reset_b     (reset_b),
        .tick        (tick),
        .parity_mode (parity_mode),
        .load        (load),
        .load_data   (load_data),
        .busy        (busy),
        .txd         (txd)
    );

    uart_rx_sample u_rx_sample (
        .clk         (clk),
        .reset_b     (reset_b),
        .tick        (tick),
        .parity_mode (parity_mode),
        .rxd         (rxd),
        .word_done   (word_done),
        .word        (word)
    );

endmodule

// ==== dv/uart_asserts.sv ====
// UART protocol assertions
`timescale 1ns/1ps

module uart_asserts (
    input logic                   clk,
    input logic                   reset_b,
    input logic                   txd,
    input logic                   tx_ready,
    input logic                   load,
    input logic                   busy,
    input logic                   rx_valid,
    input uart_bus_pkg::rx_word_t rx_word,
    input logic                   rx_ready
);

    // Line idles whenever a new host word may be taken
    property txd_idle_when_ready;
        @(posedge clk) disable iff (!reset_b) tx_ready |-> txd;
    endproperty

    // Overrun may still rise on a held word
    property rx_word_held;
        @(posedge clk) disable iff (!reset_b)
            rx_valid && !rx_ready |=> rx_valid &&
                $stable({rx_word.data, rx_word.parity_err, rx_word.frame_err});
    endproperty

    property load_only_when_idle;
        @(posedge clk) disable iff (!reset_b) !(load && busy);
    endproperty

    assert property (txd_idle_when_ready) else $error("txd low while tx_ready is high");
    assert property (rx_word_held) else $error("rx_word changed before rx_ready");
    assert property (load_only_when_idle) else $error("load issued while shifter busy");

endmodule

// ==== dv/uart_tb.sv ====
// UART subsystem testbench
`timescale 1ns/1ps

module uart_tb;
    import uart_pkg::*;
    import uart_bus_pkg::*;

    localparam int bit_cycles      = clks_per_tick * ticks_per_bit;
    localparam int loop_count      = 20;
    localparam int total_frames    = 3 * loop_count + 2 + 1 + 3;
    localparam int watchdog_cycles = total_frames * 200 + 2000;

    logic        clk;
    logic        reset_b;
    parity_e     parity_mode;
    logic        tx_valid;
    tx_word_t    tx_word;
    logic        tx_ready;
    logic        rx_valid;
    rx_word_t    rx_word;
    logic        rx_ready;
    logic        rxd;
    logic        txd;
    logic        use_driver;
    logic        drv_line;
    logic [31:0] rng;
    rx_word_t    exp_q[$];

    uart_top dut (
        .clk         (clk),
        .reset_b     (reset_b),
        .parity_mode (parity_mode),
        .tx_valid    (tx_valid),
        .tx_word     (tx_word),
        .tx_ready    (tx_ready),
        .rx_valid    (rx_valid),
        .rx_word     (rx_word),
        .rx_ready    (rx_ready),
        .rxd         (rxd),
        .txd         (txd)
    );

    bind uart_top uart_asserts u_asserts (
        .clk      (clk),
        .reset_b  (reset_b),
        .txd      (txd),
        .tx_ready (tx_ready),
        .load     (load),
        .busy     (busy),
        .rx_valid (rx_valid),
        .rx_word  (rx_word),
        .rx_ready (rx_ready)
    );

    // Loopback unless the serial driver owns the line
    assign rxd = use_driver ? drv_line : txd;

    always #4 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Parity error only exists when a parity bit is sent
    function automatic rx_word_t expected_word(input logic [7:0] data, input parity_e mode,
                                               input logic bad_parity, input logic bad_stop,
                                               input logic overrun);
        rx_word_t w;
        w.data       = data;
        w.parity_err = bad_parity && (mode != parity_none);
        w.frame_err  = bad_stop;
        w.overrun    = overrun;
        return w;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    //////////////////////////////
    // Drivers
    //////////////////////////////

    task automatic send_byte(input logic [7:0] data);
        int low_cycles;
        int frame_cycles;
        frame_cycles = ((parity_mode == parity_none) ? 10 : 11) * bit_cycles;
        low_cycles   = 0;
        tx_valid     <= 1'b1;
        tx_word.data <= data;
        do begin
            @(posedge clk);
        end while (!tx_ready);
        tx_valid <= 1'b0;
        // Start wait, every bit of the frame, then one cycle
        do begin
            @(posedge clk);
            low_cycles++;
        end while (!tx_ready && low_cycles < 4 * frame_cycles);
        assert (low_cycles >= frame_cycles + 2 &&
                low_cycles <= frame_cycles + clks_per_tick + 2)
            else abort_run($sformatf(
                "** Error at %0d ns: tx_ready low for %0d cycles, expected %0d to %0d",
                $time, low_cycles, frame_cycles + 2, frame_cycles + clks_per_tick + 2));
    endtask

    task automatic drive_bit(input logic b);
        drv_line <= b;
        repeat (bit_cycles) @(posedge clk);
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic bad_parity,
                               input logic bad_stop);
        logic par;
        par = (^data) ^ (parity_mode == parity_odd) ^ bad_parity;
        use_driver <= 1'b1;
        drive_bit(1'b0);
        for (int i = 0; i < word_bits; i++) begin
            drive_bit(data[i]);
        end
        if (parity_mode != parity_none) begin
            drive_bit(par);
        end
        drive_bit(~bad_stop);
        // Idle gap so the next start edge is clean
        drive_bit(1'b1);
        drive_bit(1'b1);
        use_driver <= 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 40 * bit_cycles) begin
            @(posedge clk);
            cycles++;
        end
        assert (exp_q.size() == 0)
            else abort_run("An expected receive word never arrived");
    endtask

    task automatic wait_overrun();
        int cycles;
        cycles = 0;
        while (!(rx_valid && rx_word.overrun) && cycles < 20 * bit_cycles) begin
            @(posedge clk);
            cycles++;
        end
        assert (rx_valid && rx_word.overrun)
            else abort_run("The held receive word never got its overrun flag");
    endtask

    task automatic check_reset();
        @(negedge clk);
        assert (txd === 1'b1)
            else abort_run($sformatf("** Error at %0d ns: txd = %b, expected 1", $time, txd));
        assert (tx_ready === 1'b1)
            else abort_run($sformatf("** Error at %0d ns: tx_ready = %b, expected 1",
                                     $time, tx_ready));
        assert (rx_valid === 1'b0)
            else abort_run($sformatf("** Error at %0d ns: rx_valid = %b, expected 0",
                                     $time, rx_valid));
        assert (rx_word === expected_word(8'hff, parity_none, 1'b0, 1'b0, 1'b0))
            else abort_run($sformatf("** Error at %0d ns: rx_word = %h, expected %h", $time,
                                     rx_word, expected_word(8'hff, parity_none, 0, 0, 0)));
        @(posedge clk);
    endtask

    //////////////////////////////
    // Comparator and watchdog
    //////////////////////////////

    always @(posedge clk) begin
        rx_word_t exp_word;
        if (reset_b && rx_valid && rx_ready) begin
            assert (exp_q.size() != 0)
                else abort_run($sformatf("Word %h received at %0d ns with none expected",
                                         rx_word, $time));
            exp_word = exp_q.pop_front();
            assert (rx_word === exp_word)
                else abort_run($sformatf("** Error at %0d ns: rx_word = %h, expected %h",
                                         $time, rx_word, exp_word));
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("Timeout: the run did not finish in the expected time");
    end

    initial begin
        clk         = 1'b0;
        reset_b     = 1'b0;
        parity_mode = parity_none;
        tx_valid    = 1'b0;
        tx_word     = '0;
        rx_ready    = 1'b1;
        use_driver  = 1'b0;
        drv_line    = 1'b1;
        rng         = 32'd28;
        repeat (16) @(posedge clk);
        reset_b <= 1'b1;
        check_reset();

        // Loopback under none, even and odd parity
        for (int m = 0; m < 3; m++) begin
            parity_mode <= parity_e'(m);
            @(posedge clk);
            for (int i = 0; i < loop_count; i++) begin
                rng = xorshift32(rng);
                exp_q.push_back(expected_word(rng[7:0], parity_e'(m), 1'b0, 1'b0, 1'b0));
                send_byte(rng[7:0]);
            end
            wait_drained();
        end

        // Inverted parity bit from the serial driver
        for (int m = 1; m < 3; m++) begin
            parity_mode <= parity_e'(m);
            @(posedge clk);
            rng = xorshift32(rng);
            exp_q.push_back(expected_word(rng[7:0], parity_e'(m), 1'b1, 1'b0, 1'b0));
            drive_frame(rng[7:0], 1'b1, 1'b0);
            wait_drained();
        end

        // Low stop bit
        parity_mode <= parity_none;
        @(posedge clk);
        rng = xorshift32(rng);
        exp_q.push_back(expected_word(rng[7:0], parity_none, 1'b0, 1'b1, 1'b0));
        drive_frame(rng[7:0], 1'b0, 1'b1);
        wait_drained();

        // Host stalls across two frames, the second is dropped
        parity_mode <= parity_even;
        rx_ready    <= 1'b0;
        @(posedge clk);
        rng = xorshift32(rng);
        exp_q.push_back(expected_word(rng[7:0], parity_even, 1'b0, 1'b0, 1'b1));
        send_byte(rng[7:0]);
        rng = xorshift32(rng);
        send_byte(rng[7:0]);
        wait_overrun();
        rx_ready <= 1'b1;
        wait_drained();
        rng = xorshift32(rng);
        exp_q.push_back(expected_word(rng[7:0], parity_even, 1'b0, 1'b0, 1'b0));
        send_byte(rng[7:0]);
        wait_drained();

        repeat (2 * bit_cycles) @(posedge clk);
        if (exp_q.size() != 0) begin
            abort_run("Run ended with receive words still outstanding");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
hw/uart_pkg.sv
hw/uart_bus_pkg.sv
hw/uart_baud_gen.sv
hw/uart_tx_shift.sv
hw/uart_rx_sample.sv
hw/uart_ctrl.sv
hw/uart_top.sv
dv/uart_asserts.sv
dv/uart_tb.sv
